//--- mem_pkg.sv
package mem_pkg;

    localparam int XLEN = 32;
    localparam int RAM_WORDS = 256;
    // word index sits at address bits 9:2
    localparam int WORD_IDX_BITS = $clog2(RAM_WORDS);

    // funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // one decoded data access
    typedef struct packed {
        logic            en;
        logic [4:0]      rd;
        logic [XLEN-1:0] addr;
        logic [3:0]      strb;
        logic            sgn;
        logic [XLEN-1:0] data;
    } mem_req_t;

    // unshifted lane mask for an access size
    function automatic logic [3:0] size_strb(size_e size);
        case (size)
            SIZE_BYTE: return 4'b0001;
            SIZE_HALF: return 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_ALU   = 3'd1,
        OP_CSR   = 3'd2,
        OP_JUMP  = 3'd3,
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5
    } op_kind_e;

    // executed operation waiting in the cushion
    typedef struct packed {
        op_kind_e                  kind;
        logic [2:0]                funct3;
        logic [4:0]                rd;
        logic [mem_pkg::XLEN-1:0]  result;
        logic [mem_pkg::XLEN-1:0]  store_data;
        logic [11:0]               csr_addr;
        logic [mem_pkg::XLEN-1:0]  csr_data;
        logic [mem_pkg::XLEN-1:0]  jmp_pc;
    } cushion_op_t;

    // decoded operation held by the read stage
    typedef struct packed {
        logic [4:0]                reg_rd;
        logic [mem_pkg::XLEN-1:0]  reg_data;
        logic                      csr_en;
        logic [11:0]               csr_addr;
        logic [mem_pkg::XLEN-1:0]  csr_data;
        mem_pkg::mem_req_t         load;
        mem_pkg::mem_req_t         store;
        logic                      jmp_do;
        logic [mem_pkg::XLEN-1:0]  jmp_pc;
    } stage_op_t;

    typedef struct packed {
        logic [4:0]                reg_rd;
        logic [mem_pkg::XLEN-1:0]  reg_data;
        logic                      csr_en;
        logic [11:0]               csr_addr;
        logic [mem_pkg::XLEN-1:0]  csr_data;
        logic                      mem_wr_en;
        logic [mem_pkg::XLEN-1:0]  mem_wr_addr;
        logic [mem_pkg::XLEN-1:0]  mem_wr_data;
        logic                      jmp_do;
        logic [mem_pkg::XLEN-1:0]  jmp_pc;
    } wb_t;

endpackage

//--- mem_decode.sv
module mem_decode (
    input  pipe_pkg::cushion_op_t op,
    output pipe_pkg::stage_op_t   dec
);

    logic [3:0] strb;
    logic       sgn;

    assign strb = mem_pkg::size_strb(mem_pkg::size_e'(op.funct3[1:0]));
    // funct3[2] set means unsigned load
    assign sgn = ~op.funct3[2];

    always_comb begin
        dec = '0;
        case (op.kind)
            pipe_pkg::OP_ALU: begin
                dec.reg_rd = op.rd;
                dec.reg_data = op.result;
            end
            pipe_pkg::OP_CSR: begin
                // rd gets the old csr value
                dec.reg_rd = op.rd;
                dec.reg_data = op.result;
                dec.csr_en = 1'b1;
                dec.csr_addr = op.csr_addr;
                dec.csr_data = op.csr_data;
            end
            pipe_pkg::OP_JUMP: begin
                // link address
                dec.reg_rd = op.rd;
                dec.reg_data = op.result;
                dec.jmp_do = 1'b1;
                dec.jmp_pc = op.jmp_pc;
            end
            pipe_pkg::OP_LOAD: begin
                dec.load.en = 1'b1;
                dec.load.rd = op.rd;
                dec.load.addr = op.result;
                dec.load.strb = strb;
                dec.load.sgn = sgn;
            end
            pipe_pkg::OP_STORE: begin
                dec.store.en = 1'b1;
                dec.store.addr = op.result;
                dec.store.strb = strb;
                dec.store.data = op.store_data;
            end
            default: begin
                dec = '0;
            end
        endcase
    end

endmodule

//--- mread.sv
module mread (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      mem_wait,
    input  pipe_pkg::stage_op_t       dec,
    output logic                      rd_en,
    output logic [mem_pkg::XLEN-1:0]  rd_addr,
    input  logic [mem_pkg::XLEN-1:0]  rd_data,
    output logic                      pending,
    output pipe_pkg::wb_t             wb
);

    pipe_pkg::stage_op_t op_q;

    logic                     dec_mem;
    logic                     held_mem;
    logic [mem_pkg::XLEN-1:0] dec_addr;
    logic [mem_pkg::XLEN-1:0] held_addr;
    logic [mem_pkg::XLEN-1:0] load_word;
    logic [mem_pkg::XLEN-1:0] store_word;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            op_q <= '0;
        end else if (!mem_wait) begin
            op_q <= dec;
        end
    end

    // stores read too, for the merge
    assign dec_mem = dec.load.en | dec.store.en;
    assign dec_addr = dec.store.en ? dec.store.addr : dec.load.addr;
    assign held_mem = op_q.load.en | op_q.store.en;
    assign held_addr = op_q.store.en ? op_q.store.addr : op_q.load.addr;

    // while stalled the request stays on the held op
    assign rd_en = mem_wait ? held_mem : dec_mem;
    assign rd_addr = mem_wait ? held_addr : dec_addr;
    assign pending = held_mem;

    // lanes are kept wide so misaligned patterns miss every legal case
    function automatic logic [mem_pkg::XLEN-1:0] load_extract(
        input logic [mem_pkg::XLEN-1:0] word,
        input logic [1:0]               off,
        input logic [3:0]               strb,
        input logic                     sgn
    );
        logic [6:0]               lanes;
        logic [mem_pkg::XLEN-1:0] sh;
        lanes = 7'(strb) << off;
        sh = word >> {off, 3'b000};
        case (lanes)
            7'b0000001, 7'b0000010, 7'b0000100, 7'b0001000:
                return {{24{sgn & sh[7]}}, sh[7:0]};
            7'b0000011, 7'b0000110, 7'b0001100:
                return {{16{sgn & sh[15]}}, sh[15:0]};
            default:
                return word;
        endcase
    endfunction

    function automatic logic [mem_pkg::XLEN-1:0] store_merge(
        input logic [mem_pkg::XLEN-1:0] old,
        input logic [1:0]               off,
        input logic [3:0]               strb,
        input logic [mem_pkg::XLEN-1:0] data
    );
        logic [6:0]               lanes;
        logic [mem_pkg::XLEN-1:0] mask;
        lanes = 7'(strb) << off;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        case (lanes)
            7'b0000001, 7'b0000010, 7'b0000100, 7'b0001000,
            7'b0000011, 7'b0000110, 7'b0001100:
                return (old & ~mask) | ((data << {off, 3'b000}) & mask);
            default:
                return data;
        endcase
    endfunction

    assign load_word = load_extract(rd_data, op_q.load.addr[1:0], op_q.load.strb,
                                    op_q.load.sgn);
    assign store_word = store_merge(rd_data, op_q.store.addr[1:0], op_q.store.strb,
                                    op_q.store.data);

    always_comb begin
        wb.reg_rd = op_q.load.en ? op_q.load.rd : op_q.reg_rd;
        wb.reg_data = op_q.load.en ? load_word : op_q.reg_data;
        wb.csr_en = op_q.csr_en;
        wb.csr_addr = op_q.csr_addr;
        wb.csr_data = op_q.csr_data;
        wb.mem_wr_en = op_q.store.en;
        wb.mem_wr_addr = op_q.store.addr;
        wb.mem_wr_data = store_word;
        wb.jmp_do = op_q.jmp_do;
        wb.jmp_pc = op_q.jmp_pc;
    end

endmodule

//--- mwrite.sv
module mwrite (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      mem_wait,
    input  pipe_pkg::wb_t             wb_in,
    output logic                      wr_en,
    output logic [mem_pkg::XLEN-1:0]  wr_addr,
    output logic [mem_pkg::XLEN-1:0]  wr_data,
    output pipe_pkg::wb_t             wb_out
);

    pipe_pkg::wb_t wb_q;

    // a stalled cycle becomes a bubble so the held op commits once
    always_ff @(posedge CLK) begin
        if (rst || mem_wait) begin
            wb_q.reg_rd <= 5'd0;
            wb_q.csr_en <= 1'b0;
            wb_q.mem_wr_en <= 1'b0;
            wb_q.jmp_do <= 1'b0;
        end else begin
            wb_q <= wb_in;
        end
    end

    assign wr_en = wb_q.mem_wr_en;
    assign wr_addr = wb_q.mem_wr_addr;
    assign wr_data = wb_q.mem_wr_data;
    assign wb_out = wb_q;

endmodule

//--- data_ram.sv
module data_ram (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      rd_en,
    input  logic [mem_pkg::XLEN-1:0]  rd_addr,
    output logic                      rd_valid,
    output logic [mem_pkg::XLEN-1:0]  rd_data,
    input  logic                      wr_en,
    input  logic [mem_pkg::XLEN-1:0]  wr_addr,
    input  logic [mem_pkg::XLEN-1:0]  wr_data
);

    logic [mem_pkg::XLEN-1:0] mem [mem_pkg::RAM_WORDS];

    logic [mem_pkg::WORD_IDX_BITS-1:0] rd_idx;
    logic [mem_pkg::WORD_IDX_BITS-1:0] wr_idx;
    logic                              hold_q;
    logic                              serve;

    assign rd_idx = rd_addr[mem_pkg::WORD_IDX_BITS+1:2];
    assign wr_idx = wr_addr[mem_pkg::WORD_IDX_BITS+1:2];

    // a read meeting a write waits one cycle, then goes regardless
    assign serve = rd_en && (hold_q || !wr_en);

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            hold_q <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            hold_q <= rd_en && !serve;
            rd_valid <= serve;
        end
    end

    // requester keeps rd_addr stable through the hold cycle
    always_ff @(posedge CLK) begin
        if (serve) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

//--- mem_stage_top.sv
module mem_stage_top (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   flush,
    input  pipe_pkg::cushion_op_t  op_in,
    output logic                   op_ready,
    output pipe_pkg::wb_t          wb_out
);

    pipe_pkg::stage_op_t dec;
    pipe_pkg::wb_t       wb_mid;

    logic                     mem_wait;
    logic                     pending;
    logic                     rd_en;
    logic                     rd_valid;
    logic                     wr_en;
    logic [mem_pkg::XLEN-1:0] rd_addr;
    logic [mem_pkg::XLEN-1:0] rd_data;
    logic [mem_pkg::XLEN-1:0] wr_addr;
    logic [mem_pkg::XLEN-1:0] wr_data;

    // stall until the held access has its data
    assign mem_wait = pending & ~rd_valid;
    assign op_ready = ~mem_wait;

    mem_decode decode_i (
        .op  (op_in),
        .dec (dec)
    );

    mread mread_i (
        .CLK      (CLK),
        .rst      (rst),
        .flush    (flush),
        .mem_wait (mem_wait),
        .dec      (dec),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .pending  (pending),
        .wb       (wb_mid)
    );

    mwrite mwrite_i (
        .CLK      (CLK),
        .rst      (rst),
        .mem_wait (mem_wait),
        .wb_in    (wb_mid),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_out   (wb_out)
    );

    data_ram ram_i (
        .CLK      (CLK),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule

//--- tb_mem_stage.sv
module tb_mem_stage;

    logic                  CLK;
    logic                  rst;
    logic                  flush;
    pipe_pkg::cushion_op_t op_in;
    logic                  op_ready;
    pipe_pkg::wb_t         wb_out;

    logic [31:0]   lfsr;
    logic [31:0]   shadow [256];
    pipe_pkg::wb_t exp_q [$];
    pipe_pkg::wb_t wb_exp;
    // stores among the last two accepted ops
    logic          recent_st [2];
    logic [7:0]    recent_idx [2];

    mem_stage_top dut_i (
        .CLK      (CLK),
        .rst      (rst),
        .flush    (flush),
        .op_in    (op_in),
        .op_ready (op_ready),
        .wb_out   (wb_out)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int byte_count(input logic [2:0] funct3);
        case (funct3[1:0])
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    // accesses that cross the word end behave as full words
    function automatic logic [31:0] extract_lane(input logic [31:0] word, input logic [1:0] off,
                                                 input logic [2:0] funct3);
        logic [31:0] sh;
        int          n;
        n = byte_count(funct3);
        if (n == 4 || int'(off) + n > 4) return word;
        sh = word >> (8 * int'(off));
        if (n == 1) return funct3[2] ? {24'd0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
        return funct3[2] ? {16'd0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] off,
                                                input logic [2:0] funct3, input logic [31:0] data);
        logic [31:0] res;
        int          n;
        int          i;
        n = byte_count(funct3);
        if (n == 4 || int'(off) + n > 4) return data;
        res = old;
        for (i = 0; i < n; i++) begin
            res[8 * (int'(off) + i) +: 8] = data[8 * i +: 8];
        end
        return res;
    endfunction

    // expected writeback, keeps the shadow memory in issue order
    function automatic pipe_pkg::wb_t expect_wb(input pipe_pkg::cushion_op_t op);
        pipe_pkg::wb_t w;
        logic [7:0]    idx;
        w = '0;
        idx = op.result[9:2];
        case (op.kind)
            pipe_pkg::OP_ALU: begin
                w.reg_rd = op.rd;
                w.reg_data = op.result;
            end
            pipe_pkg::OP_CSR: begin
                w.reg_rd = op.rd;
                w.reg_data = op.result;
                w.csr_en = 1'b1;
                w.csr_addr = op.csr_addr;
                w.csr_data = op.csr_data;
            end
            pipe_pkg::OP_JUMP: begin
                w.reg_rd = op.rd;
                w.reg_data = op.result;
                w.jmp_do = 1'b1;
                w.jmp_pc = op.jmp_pc;
            end
            pipe_pkg::OP_LOAD: begin
                w.reg_rd = op.rd;
                w.reg_data = extract_lane(shadow[idx], op.result[1:0], op.funct3);
            end
            pipe_pkg::OP_STORE: begin
                w.mem_wr_en = 1'b1;
                w.mem_wr_addr = op.result;
                w.mem_wr_data = merge_store(shadow[idx], op.result[1:0], op.funct3,
                                            op.store_data);
                shadow[idx] = w.mem_wr_data;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    function automatic logic has_enable(input pipe_pkg::wb_t w);
        return (w.reg_rd != 5'd0) || w.csr_en || w.mem_wr_en || w.jmp_do;
    endfunction

    function automatic pipe_pkg::cushion_op_t make_op(input pipe_pkg::op_kind_e kind,
                                                      input logic [2:0] funct3,
                                                      input logic [31:0] addr,
                                                      input logic [31:0] data);
        pipe_pkg::cushion_op_t op;
        op = '0;
        op.kind = kind;
        op.funct3 = funct3;
        op.rd = 5'(rand_bits(5));
        if (op.rd == 5'd0) op.rd = 5'd9;
        op.result = addr;
        op.store_data = data;
        op.csr_addr = 12'(rand_bits(12));
        op.csr_data = rand_bits(32);
        op.jmp_pc = rand_bits(30) << 2;
        return op;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            abort_run();
        end
    endtask

    // holds op_in until the DUT takes it, returns just after that edge
    task automatic present_op(input pipe_pkg::cushion_op_t op);
        int waited;
        waited = 0;
        op_in = op;
        while (!op_ready) begin
            @(posedge CLK);
            #1;
            waited++;
            if (waited > 20) begin
                $display("op_ready stayed low for more than 20 cycles");
                abort_run();
            end
        end
        @(posedge CLK);
        #1;
        op_in = '0;
    endtask

    task automatic record_issue(input logic is_store, input logic [7:0] idx);
        recent_st[1] = recent_st[0];
        recent_idx[1] = recent_idx[0];
        recent_st[0] = is_store;
        recent_idx[0] = idx;
    endtask

    task automatic send_op(input pipe_pkg::cushion_op_t op);
        pipe_pkg::wb_t w;
        logic [7:0]    idx;
        logic          is_mem;
        idx = op.result[9:2];
        is_mem = (op.kind == pipe_pkg::OP_LOAD) || (op.kind == pipe_pkg::OP_STORE);
        // two ops between a store and the next access to its word
        while (is_mem && ((recent_st[0] && recent_idx[0] == idx) ||
                          (recent_st[1] && recent_idx[1] == idx))) begin
            present_op('0);
            record_issue(1'b0, 8'd0);
        end
        present_op(op);
        record_issue(op.kind == pipe_pkg::OP_STORE, idx);
        w = expect_wb(op);
        if (has_enable(w)) exp_q.push_back(w);
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge CLK) begin
        if (!rst && has_enable(wb_out)) begin
            if (exp_q.size() == 0) begin
                $display("writeback at time %0t with nothing outstanding", $time);
                abort_run();
            end else begin
                wb_exp = exp_q.pop_front();
                check_value("wb_out.reg_rd", 32'(wb_out.reg_rd), 32'(wb_exp.reg_rd));
                check_value("wb_out.csr_en", 32'(wb_out.csr_en), 32'(wb_exp.csr_en));
                check_value("wb_out.mem_wr_en", 32'(wb_out.mem_wr_en), 32'(wb_exp.mem_wr_en));
                check_value("wb_out.jmp_do", 32'(wb_out.jmp_do), 32'(wb_exp.jmp_do));
                if (wb_exp.reg_rd != 5'd0)
                    check_value("wb_out.reg_data", wb_out.reg_data, wb_exp.reg_data);
                if (wb_exp.csr_en) begin
                    check_value("wb_out.csr_addr", 32'(wb_out.csr_addr), 32'(wb_exp.csr_addr));
                    check_value("wb_out.csr_data", wb_out.csr_data, wb_exp.csr_data);
                end
                if (wb_exp.mem_wr_en) begin
                    check_value("wb_out.mem_wr_addr", wb_out.mem_wr_addr, wb_exp.mem_wr_addr);
                    check_value("wb_out.mem_wr_data", wb_out.mem_wr_data, wb_exp.mem_wr_data);
                    check_value("wr_addr", dut_i.wr_addr, wb_exp.mem_wr_addr);
                    check_value("wr_data", dut_i.wr_data, wb_exp.mem_wr_data);
                end
                if (wb_exp.jmp_do) check_value("wb_out.jmp_pc", wb_out.jmp_pc, wb_exp.jmp_pc);
            end
        end
    end

    initial begin
        int          i;
        int          k;
        int          sel;
        int          waited;
        logic [2:0]  f3;
        logic [31:0] addr;
        lfsr = 32'hd728;
        rst = 1'b1;
        flush = 1'b0;
        op_in = '0;
        for (i = 0; i < 256; i++) shadow[i] = '0;
        for (i = 0; i < 2; i++) begin
            recent_st[i] = 1'b0;
            recent_idx[i] = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        rst = 1'b0;

        // idle after reset
        repeat (3) begin
            check_value("wb_out.reg_rd", 32'(wb_out.reg_rd), 32'd0);
            check_value("wb_out.csr_en", 32'(wb_out.csr_en), 32'd0);
            check_value("wb_out.mem_wr_en", 32'(wb_out.mem_wr_en), 32'd0);
            check_value("wb_out.jmp_do", 32'(wb_out.jmp_do), 32'd0);
            @(posedge CLK);
            #1;
        end
        waited = 0;
        while (!op_ready) begin
            @(posedge CLK);
            #1;
            waited++;
            if (waited > 10) begin
                $display("op_ready did not rise after reset");
                abort_run();
            end
        end

        // register, csr and jump pass-through
        for (i = 0; i < 12; i++) begin
            sel = int'(rand_bits(2));
            if (sel == 0) send_op(make_op(pipe_pkg::OP_CSR, 3'd0, rand_bits(32), 32'd0));
            else if (sel == 1) send_op(make_op(pipe_pkg::OP_JUMP, 3'd0, rand_bits(32), 32'd0));
            else send_op(make_op(pipe_pkg::OP_ALU, 3'd0, rand_bits(32), 32'd0));
        end

        // fill eight words, then every size, sign and offset
        for (k = 0; k < 8; k++)
            send_op(make_op(pipe_pkg::OP_STORE, 3'b010, 32'h100 + 32'(4 * k), rand_bits(32)));
        for (sel = 0; sel < 6; sel++) begin
            f3 = 3'((sel / 3) * 4 + sel % 3);
            for (k = 0; k < 4; k++) begin
                addr = 32'h100 + 32'(4 * ((sel + k) % 8)) + 32'(k);
                send_op(make_op(pipe_pkg::OP_LOAD, f3, addr, 32'd0));
            end
        end

        // sub-word stores, then read back the whole words
        for (k = 0; k < 4; k++) begin
            send_op(make_op(pipe_pkg::OP_STORE, 3'b000, 32'h104 + 32'(k), rand_bits(32)));
            send_op(make_op(pipe_pkg::OP_STORE, 3'b001, 32'h108 + 32'(k), rand_bits(32)));
        end
        send_op(make_op(pipe_pkg::OP_LOAD, 3'b010, 32'h104, 32'd0));
        send_op(make_op(pipe_pkg::OP_LOAD, 3'b010, 32'h108, 32'd0));

        // second store meets the first one's write and stalls in mread
        for (k = 0; k < 3; k++) begin
            present_op('0);
            record_issue(1'b0, 8'd0);
        end
        send_op(make_op(pipe_pkg::OP_STORE, 3'b010, 32'h150, rand_bits(32)));
        present_op('0);
        record_issue(1'b0, 8'd0);
        present_op(make_op(pipe_pkg::OP_STORE, 3'b010, 32'h154, 32'hdead_beef));
        record_issue(1'b1, 8'h55);
        if (op_ready) begin
            $display("store to 0x154 did not stall, flush case not reached");
            abort_run();
        end else begin
            flush = 1'b1;
            @(posedge CLK);
            #1;
            flush = 1'b0;
        end
        send_op(make_op(pipe_pkg::OP_LOAD, 3'b010, 32'h154, 32'd0));
        send_op(make_op(pipe_pkg::OP_LOAD, 3'b010, 32'h150, 32'd0));

        // random mix over a small window of words
        for (i = 0; i < 80; i++) begin
            sel = int'(rand_bits(2));
            addr = 32'h100 + rand_bits(5);
            f3 = 3'(rand_bits(3));
            if (sel == 0) send_op(make_op(pipe_pkg::OP_ALU, 3'd0, rand_bits(32), 32'd0));
            else if (sel == 2) send_op(make_op(pipe_pkg::OP_STORE, f3, addr, rand_bits(32)));
            else send_op(make_op(pipe_pkg::OP_LOAD, f3, addr, 32'd0));
        end

        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            @(posedge CLK);
            waited++;
        end
        if (exp_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d expected writebacks never arrived", exp_q.size());
            abort_run();
        end
    end

endmodule

//--- verilog.f
mem_pkg.sv
pipe_pkg.sv
mem_decode.sv
mread.sv
mwrite.sv
data_ram.sv
mem_stage_top.sv
tb_mem_stage.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_mem_stage -o tb_mem_stage

output="$(./obj_dir/tb_mem_stage 2>&1 || true)"
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
exit 1
